// ==== bitfieldPkg.sv ====
/* Bit-field execution unit shared definitions
   Operation codes and the width of a bit position */

package bitfieldPkg;

	// ==================================================
	// Positions
	// ==================================================

	// A bit position is seven bits wide, which reaches bit 127
	// This covers data words of 32, 64 and 128 bits
	localparam int PosBits = 7;

	// ==================================================
	// Operations
	// ==================================================

	// The caller hands one of these in with every strobe
	// The first four work on the operand through the field mask
	// The extracts and the align use the shifted operand
	typedef enum logic [2:0]
	{
		OpAndMask     = 3'd0,
		OpFieldClear  = 3'd1,
		OpFieldSet    = 3'd2,
		OpFieldChange = 3'd3,
		OpExtractU    = 3'd4,
		OpExtract     = 3'd5,
		OpAlign       = 3'd6,
		OpFindFirst   = 3'd7
	} bitfieldOp;

endpackage

// ==== maskGen.sv ====
/* Field mask generator
   Sets the bits from the begin to the end position, wrapping when end is below begin */

`timescale 1ns/10ps

module maskGen #(
	parameter int Width = 64
) (
	input  logic [bitfieldPkg::PosBits-1:0] fieldBegin,
	input  logic [bitfieldPkg::PosBits-1:0] fieldEnd,
	output logic [Width-1:0]                mask
);

	// High when the field does not wrap around the top of the word
	logic fieldNormal;

	assign fieldNormal = (fieldEnd >= fieldBegin);

	// ==================================================
	// Mask bits
	// ==================================================

	// Every bit takes the exclusive-or of three terms
	// For a normal field the third term is one, so a bit is set only
	// when it lies both at or above begin and at or below end
	// For a wrapped field the third term is zero and a bit is set when
	// exactly one of the two range tests holds, which selects the bits
	// at or above begin together with the bits at or below end
	// The gap between end and begin fails both tests and stays clear
	always_comb
	begin
		for (int n = 0; n < Width; n++)
		begin
			mask[n] = (n >= fieldBegin) ^ (n <= fieldEnd) ^ fieldNormal;
		end
	end

	// A begin equal to end gives a single-bit field
	// Begin zero with end at the top bit gives the full word
	// Positions above the word width simply never match a bit

endmodule

// ==== fieldShifter.sv ====
/* Operand shifter for the bit-field unit
   Right shift with width limiting for extracts, left shift for align */

`timescale 1ns/10ps

module fieldShifter #(
	parameter int Width = 64
) (
	input  bitfieldPkg::bitfieldOp          op,
	input  logic [Width-1:0]                a,
	input  logic [bitfieldPkg::PosBits-1:0] fieldBegin,
	input  logic [bitfieldPkg::PosBits-1:0] fieldEnd,
	output logic [Width-1:0]                shifted
);

	// Upper half of the double-width word, zeros or copies of the sign
	logic [Width-1:0]   fillWord;

	// Operand with its fill, after the right shift by begin
	logic [2*Width-1:0] wideWord;

	// Bit at position end of the shifted value, copied upward for signed extracts
	logic               fillBit;

	// Operand moved up to the begin position
	logic [Width-1:0]   alignWord;

	// ==================================================
	// Shifts
	// ==================================================

	// Only the signed extract fills with the sign of the operand
	assign fillWord = (op == bitfieldPkg::OpExtract) ? {Width{a[Width-1]}} : '0;

	// The arithmetic shift carries the top bit of the fill further down,
	// so a begin beyond the word width still yields zeros or sign bits
	assign wideWord = $signed({fillWord, a}) >>> fieldBegin;

	// Top bit of the extracted field
	assign fillBit = wideWord[fieldEnd];

	// Bits moved past the top of the word are dropped
	assign alignWord = a << fieldBegin;

	// ==================================================
	// Width limiting and select
	// ==================================================

	// The end position is read as the field width minus one
	// Everything above it is replaced by zero or by the field's top bit
	always_comb
	begin
		shifted = '0;
		case (op)
			bitfieldPkg::OpExtractU:
			begin
				for (int n = 0; n < Width; n++)
				begin
					shifted[n] = (n > fieldEnd) ? 1'b0 : wideWord[n];
				end
			end
			bitfieldPkg::OpExtract:
			begin
				for (int n = 0; n < Width; n++)
				begin
					shifted[n] = (n > fieldEnd) ? fillBit : wideWord[n];
				end
			end
			// The combiner clears the bits outside the mask afterwards
			bitfieldPkg::OpAlign:
				shifted = alignWord;
			// Mask operations and the scan have no use for this path
			default:
				shifted = '0;
		endcase
	end

endmodule

// ==== ffoScan.sv ====
/* Find-first-one scanner
   Gives the index of the highest set bit of a word and flags an all-zero word */

`timescale 1ns/10ps

module ffoScan #(
	parameter int Width = 64
) (
	input  logic [Width-1:0]                word,
	output logic [bitfieldPkg::PosBits-1:0] position,
	output logic                            none
);

	// ==================================================
	// Scan
	// ==================================================

	// Walk from the most significant bit downward
	// The first set bit met is the result, lower bits are then ignored
	// none starts high and drops once a set bit has been found
	always_comb
	begin
		position = '0;
		none     = 1'b1;
		for (int n = Width - 1; n >= 0; n--)
		begin
			if (none && word[n])
			begin
				// Index fits since the position width reaches bit 127
				position = n[bitfieldPkg::PosBits-1:0];
				none     = 1'b0;
			end
		end
	end

	// With an all-zero word position stays at zero
	// The caller looks at none before it uses the index

endmodule

// ==== bitfieldCombine.sv ====
/* Result stage of the bit-field unit
   Applies the mask, selects by operation, runs the find-first-one and registers */

`timescale 1ns/10ps

module bitfieldCombine #(
	parameter int Width = 64
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            stageValid,
	input  bitfieldPkg::bitfieldOp          op,
	input  logic [Width-1:0]                a,
	input  logic [bitfieldPkg::PosBits-1:0] fieldBegin,
	input  logic [Width-1:0]                mask,
	input  logic [Width-1:0]                shifted,
	output logic [Width-1:0]                result,
	output logic                            resultValid
);

	// Operand with everything outside the field cleared
	logic [Width-1:0]                maskedA;

	// Scanner outputs
	logic [bitfieldPkg::PosBits-1:0] ffoPos;
	logic                            ffoNone;

	// Index of the highest masked one relative to the field begin
	logic [Width-1:0]                ffoOffset;

	// Selected value, registered on the next edge
	logic [Width-1:0]                nextResult;

	// ==================================================
	// Find first one
	// ==================================================

	assign maskedA = a & mask;

	// The scanner sees only the bits inside the field
	ffoScan #(
		.Width    (Width)
	) ffoScan_i (
		.word     (maskedA),
		.position (ffoPos),
		.none     (ffoNone)
	);

	// Both terms are widened before the subtract
	// A wrapped field can put the hit below begin and the
	// difference then comes out as a negative word
	assign ffoOffset = Width'(ffoPos) - Width'(fieldBegin);

	// ==================================================
	// Result select
	// ==================================================

	always_comb
	begin
		nextResult = '0;
		case (op)
			// Keep only the field
			bitfieldPkg::OpAndMask:
				nextResult = maskedA;
			// Clear, set or invert the field, other bits pass unchanged
			bitfieldPkg::OpFieldClear:
				nextResult = a & ~mask;
			bitfieldPkg::OpFieldSet:
				nextResult = a | mask;
			bitfieldPkg::OpFieldChange:
				nextResult = a ^ mask;
			// The shifter already limited these to the field width
			bitfieldPkg::OpExtractU,
			bitfieldPkg::OpExtract:
				nextResult = shifted;
			// Bits pushed outside the field are dropped here
			bitfieldPkg::OpAlign:
				nextResult = shifted & mask;
			// All ones marks an empty field
			bitfieldPkg::OpFindFirst:
				nextResult = ffoNone ? '1 : ffoOffset;
			default:
				nextResult = '0;
		endcase
	end

	// ==================================================
	// Output register
	// ==================================================

	// The result only loads with a valid operation and holds otherwise,
	// so it stays put between result strobes
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result      <= '0;
			resultValid <= 1'b0;
		end
		else
		begin
			resultValid <= stageValid;
			if (stageValid)
			begin
				result <= nextResult;
			end
		end
	end

endmodule

// ==== bitfieldUnit.sv ====
/* Bit-field execution unit, top level
   Registers the operation, then builds the mask and shifts the operand in parallel */

`timescale 1ns/10ps

module bitfieldUnit #(
	parameter int Width = 64
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            valid,
	input  bitfieldPkg::bitfieldOp          op,
	input  logic [Width-1:0]                a,
	input  logic [bitfieldPkg::PosBits-1:0] fieldBegin,
	input  logic [bitfieldPkg::PosBits-1:0] fieldEnd,
	output logic [Width-1:0]                result,
	output logic                            resultValid
);

	// Stage one holds the accepted operation for one cycle
	bitfieldPkg::bitfieldOp          stageOp;
	logic [Width-1:0]                stageA;
	logic [bitfieldPkg::PosBits-1:0] stageBegin;
	logic [bitfieldPkg::PosBits-1:0] stageEnd;
	logic                            stageValid;

	// Outputs of the two parallel parts
	logic [Width-1:0]                mask;
	logic [Width-1:0]                shifted;

	// ==================================================
	// Stage one registers
	// ==================================================

	// The operand registers load only on a strobe
	// A strobe is taken every cycle since the unit never stalls
	always_ff @(posedge clk)
	begin
		if (valid)
		begin
			stageOp    <= op;
			stageA     <= a;
			stageBegin <= fieldBegin;
			stageEnd   <= fieldEnd;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			stageValid <= 1'b0;
		else
			stageValid <= valid;
	end

	// ==================================================
	// Mask and shift, side by side
	// ==================================================

	maskGen #(
		.Width      (Width)
	) maskGen_i (
		.fieldBegin (stageBegin),
		.fieldEnd   (stageEnd),
		.mask       (mask)
	);

	fieldShifter #(
		.Width      (Width)
	) fieldShifter_i (
		.op         (stageOp),
		.a          (stageA),
		.fieldBegin (stageBegin),
		.fieldEnd   (stageEnd),
		.shifted    (shifted)
	);

	// Second cycle, select and register the result
	bitfieldCombine #(
		.Width       (Width)
	) bitfieldCombine_i (
		.clk         (clk),
		.reset       (reset),
		.stageValid  (stageValid),
		.op          (stageOp),
		.a           (stageA),
		.fieldBegin  (stageBegin),
		.mask        (mask),
		.shifted     (shifted),
		.result      (result),
		.resultValid (resultValid)
	);

endmodule

// ==== bitfieldUnitTb.sv ====
/* Testbench for the bit-field execution unit
   Plays the stored patterns with random gaps and checks every result in order */

`timescale 1ns/10ps

module bitfieldUnitTb;

	// ==================================================
	// Constants
	// ==================================================

	localparam int Width            = 64;
	localparam int PatternCount     = 38;
	localparam int FieldsPerPattern = 5;
	localparam int ResetCycles      = 10;
	localparam int TimeoutMargin    = 20;
	// One strobe plus at most two idle cycles per pattern fits well inside five
	localparam int CycleLimit       = PatternCount * 5 + ResetCycles + TimeoutMargin;
	localparam logic [31:0] Seed    = 32'he8a6;
	// Driven after edge j, taken at edge j+1, registered as a result at edge j+2
	localparam int Latency          = 2;

	logic                            clk;
	logic                            reset;
	logic                            valid;
	bitfieldPkg::bitfieldOp          op;
	logic [Width-1:0]                a;
	logic [bitfieldPkg::PosBits-1:0] fieldBegin;
	logic [bitfieldPkg::PosBits-1:0] fieldEnd;
	logic [Width-1:0]                result;
	logic                            resultValid;

	// Five words per pattern in the order of the file
	logic [Width-1:0]                rawPatterns [0:PatternCount*FieldsPerPattern-1];
	bitfieldPkg::bitfieldOp          opList      [0:PatternCount-1];
	logic [bitfieldPkg::PosBits-1:0] beginList   [0:PatternCount-1];
	logic [bitfieldPkg::PosBits-1:0] endList     [0:PatternCount-1];
	logic [Width-1:0]                operandList [0:PatternCount-1];
	logic [Width-1:0]                expectList  [0:PatternCount-1];

	// Operations in flight with the oldest at the front
	logic [Width-1:0]                expectQ [$];
	bitfieldPkg::bitfieldOp          opQ     [$];
	int                              indexQ  [$];
	int                              cycleQ  [$];

	// Value the result output has to keep between strobes
	logic [Width-1:0]                heldResult;

	int                              cycleCount;
	int                              pulseCount;
	int                              passCount;
	int                              failCount;
	int                              errorCount;
	logic [31:0]                     rngState;

	bitfieldUnit #(
		.Width       (Width)
	) bitfieldUnit_i (
		.clk         (clk),
		.reset       (reset),
		.valid       (valid),
		.op          (op),
		.a           (a),
		.fieldBegin  (fieldBegin),
		.fieldEnd    (fieldEnd),
		.result      (result),
		.resultValid (resultValid)
	);

	// 40 ns period
	always
	begin
		#20 clk = ~clk;
	end

	// Cycle counter and run limit
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit)
		begin
			$display("Timeout after %0d cycles, %0d of %0d results seen",
				cycleCount, pulseCount, PatternCount);
			$display("Test failures found");
			$finish;
		end
	end

	// ==================================================
	// Helpers
	// ==================================================

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] x;
		begin
			x = state;
			x = x ^ (x << 13);
			x = x ^ (x >> 17);
			x = x ^ (x << 5);
			return x;
		end
	endfunction

	task automatic checkResult(input int index, input bitfieldPkg::bitfieldOp opCode,
		input logic [Width-1:0] expected, input logic [Width-1:0] actual);
		begin
			if (actual !== expected)
			begin
				$display("ERR time %0t signal result test %0d %s expected %h actual %h",
					$time, index, opCode.name(), expected, actual);
				errorCount++;
			end
		end
	endtask

	task automatic checkWord(input string name, input logic [Width-1:0] expected,
		input logic [Width-1:0] actual);
		begin
			if (actual !== expected)
			begin
				$display("ERR time %0t signal %s expected %h actual %h",
					$time, name, expected, actual);
				errorCount++;
			end
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		begin
			if (actual !== expected)
			begin
				$display("ERR time %0t signal %s expected %b actual %b",
					$time, name, expected, actual);
				errorCount++;
			end
		end
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		begin
			if (actual != expected)
			begin
				$display("ERR time %0t signal %s expected %0d actual %0d",
					$time, name, expected, actual);
				errorCount++;
			end
		end
	endtask

	// Puts one pattern on the inputs and remembers what should come back
	task automatic driveOperation(input int index);
		begin
			valid      = 1'b1;
			op         = opList[index];
			a          = operandList[index];
			fieldBegin = beginList[index];
			fieldEnd   = endList[index];
			expectQ.push_back(expectList[index]);
			opQ.push_back(opList[index]);
			indexQ.push_back(index);
			cycleQ.push_back(cycleCount);
		end
	endtask

	// ==================================================
	// Result monitor
	// ==================================================

	// Sampled on the falling edge where no register changes
	always @(negedge clk)
	begin : resultMonitor
		logic [Width-1:0]       expected;
		bitfieldPkg::bitfieldOp opCode;
		int                     index;
		int                     driveCycle;
		int                     errorsBefore;
		if (!reset && resultValid === 1'b1)
		begin
			pulseCount++;
			if (expectQ.size() == 0)
			begin
				$display("Result strobe at time %0t with no operation in flight", $time);
				errorCount++;
			end
			else
			begin
				expected     = expectQ.pop_front();
				opCode       = opQ.pop_front();
				index        = indexQ.pop_front();
				driveCycle   = cycleQ.pop_front();
				errorsBefore = errorCount;
				heldResult   = expected;
				checkResult(index, opCode, expected, result);
				if (cycleCount - driveCycle != Latency)
				begin
					$display("Test %0d arrived %0d cycles after it was driven, not %0d",
						index, cycleCount - driveCycle, Latency);
					errorCount++;
				end
				if (errorCount == errorsBefore)
				begin
					passCount++;
					$display("Test %0d %s passed", index, opCode.name());
				end
				else
					failCount++;
			end
		end
		else if (!reset)
		begin
			// Without a strobe the output keeps the last result
			checkWord("result", heldResult, result);
		end
	end

	// ==================================================
	// Stimulus
	// ==================================================

	initial
	begin
		int gap;
		int errorsBefore;
		clk        = 1'b0;
		reset      = 1'b1;
		valid      = 1'b0;
		op         = bitfieldPkg::OpAndMask;
		a          = '0;
		fieldBegin = '0;
		fieldEnd   = '0;
		heldResult = '0;
		cycleCount = 0;
		pulseCount = 0;
		passCount  = 0;
		failCount  = 0;
		errorCount = 0;
		rngState   = Seed;

		// Unknown words show up a short pattern file
		for (int n = 0; n < PatternCount * FieldsPerPattern; n++)
			rawPatterns[n] = 'x;
		$readmemh("bitfieldPatterns.txt", rawPatterns);
		if (rawPatterns[PatternCount*FieldsPerPattern-1] === 'x)
		begin
			$display("The pattern file holds fewer than %0d complete patterns", PatternCount);
			errorCount++;
		end
		for (int i = 0; i < PatternCount; i++)
		begin
			opList[i]      = bitfieldPkg::bitfieldOp'(rawPatterns[i*FieldsPerPattern][2:0]);
			beginList[i]   = rawPatterns[i*FieldsPerPattern+1][bitfieldPkg::PosBits-1:0];
			endList[i]     = rawPatterns[i*FieldsPerPattern+2][bitfieldPkg::PosBits-1:0];
			operandList[i] = rawPatterns[i*FieldsPerPattern+3];
			expectList[i]  = rawPatterns[i*FieldsPerPattern+4];
		end

		repeat (ResetCycles) @(posedge clk);
		#1 reset = 1'b0;

		// Output stays quiet and zero until the first strobe
		errorsBefore = errorCount;
		repeat (2)
		begin
			@(negedge clk);
			checkFlag("resultValid", 1'b0, resultValid);
			checkWord("result", '0, result);
		end
		if (errorCount == errorsBefore)
			$display("Reset state test passed");
		else
			$display("Reset state test failed");

		@(posedge clk);
		#1;
		for (int i = 0; i < PatternCount; i++)
		begin
			driveOperation(i);
			@(posedge clk);
			#1;
			// Zero to two idle cycles follow each strobe
			// A gap of zero keeps the strobes back to back
			rngState = xorshift(rngState);
			gap      = int'(rngState % 32'd3);
			if (gap > 0)
			begin
				valid = 1'b0;
				repeat (gap)
				begin
					@(posedge clk);
					#1;
				end
			end
		end
		valid = 1'b0;

		wait (pulseCount >= PatternCount);
		// A few more cycles catch any stray strobe
		repeat (4) @(negedge clk);
		checkCount("resultValid pulses", PatternCount, pulseCount);
		checkCount("operations in flight", 0, expectQ.size());

		$display("Tests passed %0d, tests failed %0d, check errors %0d",
			passCount, failCount, errorCount);
		if (errorCount == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== bitfieldPatterns.txt ====
// Columns: op, begin, end, operand, expected result, all hex
// op codes 0 AndMask, 1 FieldClear, 2 FieldSet, 3 FieldChange, 4 ExtractU, 5 Extract, 6 Align, 7 FindFirst
// Mask operations, normal, full, single-bit and wrapped fields
0 08 0F 0123456789ABCDEF 000000000000CD00
0 00 3F 0123456789ABCDEF 0123456789ABCDEF
0 05 05 0123456789ABCDEF 0000000000000020
0 3C 03 FEDCBA9876543210 F000000000000000
1 08 0F 0123456789ABCDEF 0123456789AB00EF
1 00 3F FEDCBA9876543210 0000000000000000
1 3F 3F FEDCBA9876543210 7EDCBA9876543210
1 38 07 0123456789ABCDEF 0023456789ABCD00
2 10 1F 0123456789ABCDEF 01234567FFFFCDEF
2 00 00 FEDCBA9876543210 FEDCBA9876543211
2 3E 01 0000000000000000 C000000000000003
2 00 3F 0123456789ABCDEF FFFFFFFFFFFFFFFF
3 04 0B 0123456789ABCDEF 0123456789ABC21F
3 00 3F 0123456789ABCDEF FEDCBA9876543210
3 20 0F FEDCBA9876543210 012345677654CDEF
// Extracts, end holds the field width minus one
4 00 07 0123456789ABCDEF 00000000000000EF
4 08 0F 0123456789ABCDEF 000000000000ABCD
4 3C 03 FEDCBA9876543210 000000000000000F
4 3F 00 FEDCBA9876543210 0000000000000001
4 04 3F FEDCBA9876543210 0FEDCBA987654321
5 00 07 0123456789ABCDEF FFFFFFFFFFFFFFEF
5 08 07 0123456789ABCDEF FFFFFFFFFFFFFFCD
5 10 0F 0123456789ABCDEF FFFFFFFFFFFF89AB
5 18 0F 0123456789ABCDEF 0000000000006789
5 3F 00 FEDCBA9876543210 FFFFFFFFFFFFFFFF
5 04 3F FEDCBA9876543210 FFEDCBA987654321
5 38 07 0123456789ABCDEF 0000000000000001
// Align into the field
6 08 0F 0123456789ABCDEF 000000000000EF00
6 00 3F FEDCBA9876543210 FEDCBA9876543210
6 3C 3F 0123456789ABCDEF F000000000000000
6 10 17 FEDCBA9876543210 0000000000100000
// Find first one, offset from begin, all ones when the field is empty
7 00 3F 0123456789ABCDEF 0000000000000038
7 08 0F 0123456789ABCDEF 0000000000000007
7 04 07 FEDCBA9876543210 0000000000000000
7 00 03 FEDCBA9876543210 FFFFFFFFFFFFFFFF
7 20 2F 0123456789ABCDEF 000000000000000E
7 3C 03 0123456789ABCDEF FFFFFFFFFFFFFFC7
7 3F 3F FEDCBA9876543210 0000000000000000

// ==== files.f ====
bitfieldPkg.sv
maskGen.sv
fieldShifter.sv
ffoScan.sv
bitfieldCombine.sv
bitfieldUnit.sv
bitfieldUnitTb.sv

// ==== Makefile ====
# Verilator build, run, lint and clean for the bit-field unit

TOP = bitfieldUnitTb

.PHONY: all lint clean

# Build, run, and fail unless the pass message shows up in the output
all:
	verilator --binary --timing -Wno-fatal -f files.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "All tests passed!"

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir
